//--- Makefile
TOP = branch_predictor_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   list these targets"

test:
	verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "Test completed successfully"

clean:
	rm -rf obj_dir

//--- logic/bp_pkg.sv
`default_nettype none

package bp_pkg;

    // Address width
    localparam int xlen = 32;

    typedef logic [xlen-1:0] pc_t;

    // Gshare table, indexed by PC[9:2] xor history
    localparam int pht_entries = 256;
    localparam int pht_index_w = 8;

    typedef logic [pht_index_w-1:0] pht_index_t;

    // Two-bit saturating counter states
    typedef enum logic [1:0] {
        strong_not_taken = 2'd0,
        weak_not_taken   = 2'd1,
        weak_taken       = 2'd2,
        strong_taken     = 2'd3
    } counter_t;

    // Direct-mapped target buffer, slot from PC[7:2], tag from PC[31:8]
    localparam int btb_entries = 64;
    localparam int btb_index_w = 6;
    localparam int btb_tag_w   = 24;

    typedef enum logic {
        kind_branch = 1'b0,
        kind_jump   = 1'b1
    } branch_kind_t;

    // Statistics widths
    localparam int stat_w  = 16;
    localparam int cycle_w = 28;

endpackage

`default_nettype wire

//--- logic/bp_resolve_if.sv
`timescale 1ns/1ns
`default_nettype none

// One resolved branch per valid cycle, no backpressure
interface bp_resolve_if;

    logic                 valid;
    bp_pkg::pc_t          pc;
    bp_pkg::pht_index_t   index;
    bp_pkg::counter_t     counter;
    logic                 taken;
    bp_pkg::branch_kind_t kind;
    bp_pkg::pc_t          target;

    modport sink (
        input valid,
        input pc,
        input index,
        input counter,
        input taken,
        input kind,
        input target
    );

endinterface

`default_nettype wire

//--- logic/branch_predictor_top.sv
`timescale 1ns/1ns
`default_nettype none

module branch_predictor_top (
    input  logic                       clk,
    input  logic                       rst_n,

    // Fetch lookup
    input  logic                       lookup_valid,
    input  bp_pkg::pc_t                lookup_pc,

    // Resolve from execute
    input  logic                       resolve_valid,
    input  bp_pkg::pc_t                resolve_pc,
    input  bp_pkg::pht_index_t         resolve_index,
    input  bp_pkg::counter_t           resolve_counter,
    input  logic                       resolve_taken,
    input  bp_pkg::branch_kind_t       resolve_kind,
    input  bp_pkg::pc_t                resolve_target,

    // Prediction, one cycle after the lookup
    output logic                       pred_valid,
    output bp_pkg::pc_t                pred_pc,
    output bp_pkg::pht_index_t         pred_index,
    output bp_pkg::counter_t           pred_counter,
    output logic                       btb_hit,
    output logic                       pred_taken,
    output bp_pkg::pc_t                pred_next_pc,

    // Statistics
    output logic [bp_pkg::cycle_w-1:0] cycle_count,
    output logic [bp_pkg::stat_w-1:0]  predictions_made,
    output logic [bp_pkg::stat_w-1:0]  correct_predictions
);

    import bp_pkg::*;

    pc_t          btb_target;
    branch_kind_t btb_kind;

    bp_resolve_if resolve_bus ();

    assign resolve_bus.valid   = resolve_valid;
    assign resolve_bus.pc      = resolve_pc;
    assign resolve_bus.index   = resolve_index;
    assign resolve_bus.counter = resolve_counter;
    assign resolve_bus.taken   = resolve_taken;
    assign resolve_bus.kind    = resolve_kind;
    assign resolve_bus.target  = resolve_target;

    pattern_history_table u_pattern_history_table (
        .clk          (clk),
        .rst_n        (rst_n),
        .lookup_valid (lookup_valid),
        .lookup_pc    (lookup_pc),
        .resolve      (resolve_bus),
        .pht_index    (pred_index),
        .pht_counter  (pred_counter)
    );

    branch_target_buffer u_branch_target_buffer (
        .clk          (clk),
        .rst_n        (rst_n),
        .lookup_valid (lookup_valid),
        .lookup_pc    (lookup_pc),
        .resolve      (resolve_bus),
        .btb_hit      (btb_hit),
        .btb_target   (btb_target),
        .btb_kind     (btb_kind)
    );

    fetch_predict u_fetch_predict (
        .clk          (clk),
        .rst_n        (rst_n),
        .lookup_valid (lookup_valid),
        .lookup_pc    (lookup_pc),
        .pht_counter  (pred_counter),
        .btb_hit      (btb_hit),
        .btb_target   (btb_target),
        .btb_kind     (btb_kind),
        .pred_valid   (pred_valid),
        .pred_pc      (pred_pc),
        .pred_taken   (pred_taken),
        .pred_next_pc (pred_next_pc)
    );

    prediction_counters u_prediction_counters (
        .clk                 (clk),
        .rst_n               (rst_n),
        .resolve             (resolve_bus),
        .cycle_count         (cycle_count),
        .predictions_made    (predictions_made),
        .correct_predictions (correct_predictions)
    );

endmodule

`default_nettype wire

//--- logic/branch_target_buffer.sv
`timescale 1ns/1ns
`default_nettype none

module branch_target_buffer (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 lookup_valid,
    input  bp_pkg::pc_t          lookup_pc,
    bp_resolve_if.sink           resolve,
    output logic                 btb_hit,
    output bp_pkg::pc_t          btb_target,
    output bp_pkg::branch_kind_t btb_kind
);

    import bp_pkg::*;

    logic [btb_entries-1:0] slot_valid;
    logic [btb_tag_w-1:0]   slot_tag    [btb_entries];
    pc_t                    slot_target [btb_entries];
    branch_kind_t           slot_kind   [btb_entries];

    logic [btb_index_w-1:0] lookup_slot;
    logic [btb_tag_w-1:0]   lookup_tag;
    logic [btb_index_w-1:0] write_slot;

    assign lookup_slot = lookup_pc[btb_index_w+1:2];
    assign lookup_tag  = lookup_pc[xlen-1:btb_index_w+2];
    assign write_slot  = resolve.pc[btb_index_w+1:2];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            slot_valid <= '0;
            btb_hit    <= 1'b0;
        end else begin
            if (lookup_valid) begin
                btb_hit <= slot_valid[lookup_slot] && (slot_tag[lookup_slot] == lookup_tag);
            end
            if (resolve.valid) begin
                slot_valid[write_slot] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (lookup_valid) begin
            btb_target <= slot_target[lookup_slot];
            btb_kind   <= slot_kind[lookup_slot];
        end
        // Resolve overwrites whatever held the slot before
        if (resolve.valid) begin
            slot_tag[write_slot]    <= resolve.pc[xlen-1:btb_index_w+2];
            slot_target[write_slot] <= resolve.target;
            slot_kind[write_slot]   <= resolve.kind;
        end
    end

endmodule

`default_nettype wire

//--- logic/fetch_predict.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_predict (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 lookup_valid,
    input  bp_pkg::pc_t          lookup_pc,
    input  bp_pkg::counter_t     pht_counter,
    input  logic                 btb_hit,
    input  bp_pkg::pc_t          btb_target,
    input  bp_pkg::branch_kind_t btb_kind,
    output logic                 pred_valid,
    output bp_pkg::pc_t          pred_pc,
    output logic                 pred_taken,
    output bp_pkg::pc_t          pred_next_pc
);

    import bp_pkg::*;

    logic counter_says_taken;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pred_valid <= 1'b0;
        end else begin
            pred_valid <= lookup_valid;
        end
    end

    // Lines up with the registered table reads
    always_ff @(posedge clk) begin
        if (lookup_valid) begin
            pred_pc <= lookup_pc;
        end
    end

    assign counter_says_taken = (pht_counter == weak_taken) || (pht_counter == strong_taken);

    // Jumps always redirect on a hit, branches follow the counter
    assign pred_taken = btb_hit && ((btb_kind == kind_jump) || counter_says_taken);

    assign pred_next_pc = pred_taken ? btb_target : pred_pc + 32'd4;

endmodule

`default_nettype wire

//--- logic/pattern_history_table.sv
`timescale 1ns/1ns
`default_nettype none

module pattern_history_table (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               lookup_valid,
    input  bp_pkg::pc_t        lookup_pc,
    bp_resolve_if.sink         resolve,
    output bp_pkg::pht_index_t pht_index,
    output bp_pkg::counter_t   pht_counter
);

    import bp_pkg::*;

    counter_t   counters [pht_entries];
    pht_index_t history;
    pht_index_t lookup_index;
    counter_t   stepped;

    // Gshare hash
    assign lookup_index = lookup_pc[pht_index_w+1:2] ^ history;

    // Saturating step of the entry being resolved
    always_comb begin
        stepped = counters[resolve.index];
        case (counters[resolve.index])
            strong_not_taken: stepped = resolve.taken ? weak_not_taken : strong_not_taken;
            weak_not_taken:   stepped = resolve.taken ? weak_taken : strong_not_taken;
            weak_taken:       stepped = resolve.taken ? strong_taken : weak_not_taken;
            strong_taken:     stepped = resolve.taken ? strong_taken : weak_taken;
            default:          stepped = weak_not_taken;
        endcase
    end

    // Table and history update, old contents still seen by a same-edge lookup
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            history <= '0;
            for (int i = 0; i < pht_entries; i++) begin
                counters[i] <= weak_not_taken;
            end
        end else if (resolve.valid) begin
            history                 <= {history[pht_index_w-2:0], resolve.taken};
            counters[resolve.index] <= stepped;
        end
    end

    // Registered read, index travels with the branch to execute
    always_ff @(posedge clk) begin
        if (lookup_valid) begin
            pht_index   <= lookup_index;
            pht_counter <= counters[lookup_index];
        end
    end

endmodule

`default_nettype wire

//--- logic/prediction_counters.sv
`timescale 1ns/1ns
`default_nettype none

module prediction_counters (
    input  logic                      clk,
    input  logic                      rst_n,
    bp_resolve_if.sink                resolve,
    output logic [bp_pkg::cycle_w-1:0] cycle_count,
    output logic [bp_pkg::stat_w-1:0]  predictions_made,
    output logic [bp_pkg::stat_w-1:0]  correct_predictions
);

    import bp_pkg::*;

    logic branch_resolved;
    logic predicted_taken;

    // Jumps are not counted
    assign branch_resolved = resolve.valid && (resolve.kind == kind_branch);

    // Taken bit the counter implied at fetch time
    assign predicted_taken = (resolve.counter == weak_taken) ||
                             (resolve.counter == strong_taken);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cycle_count         <= '0;
            predictions_made    <= '0;
            correct_predictions <= '0;
        end else begin
            cycle_count <= cycle_count + 1'b1;
            if (branch_resolved) begin
                predictions_made <= predictions_made + 1'b1;
                if (predicted_taken == resolve.taken) begin
                    correct_predictions <= correct_predictions + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- sim.f
logic/bp_pkg.sv
logic/bp_resolve_if.sv
logic/pattern_history_table.sv
logic/branch_target_buffer.sv
logic/fetch_predict.sv
logic/prediction_counters.sv
logic/branch_predictor_top.sv
verification/tb_clock.sv
verification/branch_predictor_tb.sv

//--- verification/branch_predictor_tb.sv
`timescale 1ns/1ns
`default_nettype none

module branch_predictor_tb;

    import bp_pkg::*;

    logic          clk;
    logic          rst_n;
    logic          lookup_valid;
    pc_t           lookup_pc;
    logic          resolve_valid;
    pc_t           resolve_pc;
    pht_index_t    resolve_index;
    counter_t      resolve_counter;
    logic          resolve_taken;
    branch_kind_t  resolve_kind;
    pc_t           resolve_target;
    logic          pred_valid;
    pc_t           pred_pc;
    pht_index_t    pred_index;
    counter_t      pred_counter;
    logic          btb_hit;
    logic          pred_taken;
    pc_t           pred_next_pc;
    logic [27:0]   cycle_count;
    logic [15:0]   predictions_made;
    logic [15:0]   correct_predictions;

    // Reference model state
    logic [1:0]    m_pht [256];
    logic [7:0]    m_hist;
    logic          m_btb_valid [64];
    logic [23:0]   m_btb_tag [64];
    pc_t           m_btb_target [64];
    logic          m_btb_jump [64];
    int            branch_resolves;
    int            m_correct;

    // Expected lookup result as driven and as seen one edge later
    logic          chk_d, chk_q;
    pc_t           exp_pc_d, exp_pc_q;
    logic [7:0]    exp_index_d, exp_index_q;
    logic [1:0]    exp_counter_d, exp_counter_q;
    logic          exp_hit_d, exp_hit_q;
    logic          exp_taken_d, exp_taken_q;
    pc_t           exp_next_d, exp_next_q;
    logic [15:0]   made_q;
    logic [15:0]   correct_q;
    logic [27:0]   tally;

    int            errors;
    int            lookups;
    int            resolves;
    int            tests_run;
    int            test_start_errors;
    logic [31:0]   lcg_state;

    tb_clock u_tb_clock (
        .clk (clk)
    );

    branch_predictor_top u_branch_predictor_top (.*);

    always @(posedge clk) begin
        chk_q         <= chk_d;
        exp_pc_q      <= exp_pc_d;
        exp_index_q   <= exp_index_d;
        exp_counter_q <= exp_counter_d;
        exp_hit_q     <= exp_hit_d;
        exp_taken_q   <= exp_taken_d;
        exp_next_q    <= exp_next_d;
        made_q        <= 16'(branch_resolves);
        correct_q     <= 16'(m_correct);
        tally         <= rst_n ? tally + 28'd1 : 28'd0;
    end

    assert property (@(posedge clk) disable iff (!rst_n) chk_q |-> (pred_valid &&
        pred_pc == exp_pc_q && pred_index == exp_index_q && pred_counter == exp_counter_q))
    else begin
        $display("Mismatch at %0t: lookup %h index %h counter %0d, expected index %h counter %0d",
                 $time, $sampled(pred_pc), $sampled(pred_index), $sampled(pred_counter),
                 $sampled(exp_index_q), $sampled(exp_counter_q));
        errors++;
    end

    assert property (@(posedge clk) disable iff (!rst_n) chk_q |-> (btb_hit == exp_hit_q &&
        pred_taken == exp_taken_q && pred_next_pc == exp_next_q))
    else begin
        $display("Mismatch at %0t: pc %h hit %b taken %b next %h, expected %b %b %h",
                 $time, $sampled(exp_pc_q), $sampled(btb_hit), $sampled(pred_taken),
                 $sampled(pred_next_pc), $sampled(exp_hit_q), $sampled(exp_taken_q),
                 $sampled(exp_next_q));
        errors++;
    end

    assert property (@(posedge clk) disable iff (!rst_n) !chk_q |-> !pred_valid)
    else begin
        $display("Mismatch at %0t: pred_valid high without a lookup", $time);
        errors++;
    end

    assert property (@(posedge clk) disable iff (!rst_n) (predictions_made == made_q &&
        correct_predictions == correct_q && cycle_count == tally))
    else begin
        $display("Mismatch at %0t: stats %0d/%0d/%0d, expected %0d/%0d/%0d", $time,
                 $sampled(cycle_count), $sampled(predictions_made),
                 $sampled(correct_predictions), $sampled(tally), $sampled(made_q),
                 $sampled(correct_q));
        errors++;
    end

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [1:0] saturate_step(logic [1:0] c, logic taken);
        if (taken) begin
            return (c == 2'd3) ? 2'd3 : c + 2'd1;
        end
        return (c == 2'd0) ? 2'd0 : c - 2'd1;
    endfunction

    // One cycle of fetch and execute traffic where the model reads before it writes
    task automatic drive_cycle(input logic lv, input pc_t lpc, input logic rv, input pc_t rpc,
                               input pht_index_t ridx, input counter_t rcnt, input logic rtaken,
                               input branch_kind_t rkind, input pc_t rtgt);
        logic [7:0] idx;
        logic [5:0] slot;
        lookup_valid    = lv;
        lookup_pc       = lpc;
        resolve_valid   = rv;
        resolve_pc      = rpc;
        resolve_index   = ridx;
        resolve_counter = rcnt;
        resolve_taken   = rtaken;
        resolve_kind    = rkind;
        resolve_target  = rtgt;
        chk_d = lv;
        if (lv) begin
            idx           = lpc[9:2] ^ m_hist;
            slot          = lpc[7:2];
            exp_pc_d      = lpc;
            exp_index_d   = idx;
            exp_counter_d = m_pht[idx];
            exp_hit_d     = m_btb_valid[slot] && (m_btb_tag[slot] == lpc[31:8]);
            exp_taken_d   = exp_hit_d && (m_btb_jump[slot] || m_pht[idx] >= 2'd2);
            exp_next_d    = exp_taken_d ? m_btb_target[slot] : lpc + 32'd4;
            lookups++;
        end
        if (rv) begin
            slot                = rpc[7:2];
            m_pht[ridx]         = saturate_step(m_pht[ridx], rtaken);
            m_hist              = {m_hist[6:0], rtaken};
            m_btb_valid[slot]   = 1'b1;
            m_btb_tag[slot]     = rpc[31:8];
            m_btb_target[slot]  = rtgt;
            m_btb_jump[slot]    = (rkind == kind_jump);
            resolves++;
            if (rkind == kind_branch) begin
                branch_resolves++;
                if ((rcnt >= weak_taken) == rtaken) begin
                    m_correct++;
                end
            end
        end
        @(posedge clk);
        #1;
    endtask

    task automatic lookup_only(input pc_t pc);
        drive_cycle(1'b1, pc, 1'b0, '0, '0, weak_not_taken, 1'b0, kind_branch, '0);
    endtask

    task automatic resolve_only(input pc_t pc, input pht_index_t idx, input counter_t cnt,
                                input logic taken, input branch_kind_t kind, input pc_t tgt);
        drive_cycle(1'b0, '0, 1'b1, pc, idx, cnt, taken, kind, tgt);
    endtask

    task automatic start_test();
        tests_run++;
        test_start_errors = errors;
    endtask

    task automatic report_test(input string name);
        $display("test %0d %s: %0d errors", tests_run, name, errors - test_start_errors);
    endtask

    task automatic wait_pred_idle();
        int n;
        n = 0;
        while (pred_valid && n < 20) begin
            drive_cycle(1'b0, '0, 1'b0, '0, '0, weak_not_taken, 1'b0, kind_branch, '0);
            n++;
        end
        if (pred_valid) begin
            $display("Timeout: pred_valid stayed high with no lookups issued");
            errors++;
        end
    endtask

    initial begin
        logic [31:0]  rnd;
        pc_t          br_pc;
        pc_t          jmp_pc;
        pc_t          l_pc;
        pc_t          r_pc;
        pht_index_t   r_idx;
        counter_t     r_cnt;
        branch_kind_t r_kind;
        logic         r_taken;
        logic         l_valid;
        logic         do_resolve;
        int           tries;
        pc_t          q_pc [$];
        pht_index_t   q_idx [$];
        counter_t     q_cnt [$];

        lcg_state = 32'hbad2_8d2a;
        errors = 0;
        lookups = 0;
        resolves = 0;
        tests_run = 0;
        branch_resolves = 0;
        m_correct = 0;
        m_hist = '0;
        chk_d = 1'b0;
        for (int i = 0; i < 256; i++) begin
            m_pht[i] = 2'd1;
        end
        for (int i = 0; i < 64; i++) begin
            m_btb_valid[i] = 1'b0;
            m_btb_jump[i] = 1'b0;
        end
        rst_n = 1'b0;
        drive_cycle(1'b0, '0, 1'b0, '0, '0, weak_not_taken, 1'b0, kind_branch, '0);
        repeat (7) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // Cold predictor
        start_test();
        assert (cycle_count == 0 && predictions_made == 0 && correct_predictions == 0 &&
                !pred_valid)
        else begin
            $display("Mismatch at %0t: state not cleared by reset", $time);
            errors++;
        end
        for (int i = 0; i < 4; i++) begin
            rnd = next_random();
            l_pc = {rnd[31:2], 2'b00};
            lookup_only(l_pc);
            assert (!btb_hit && pred_counter == weak_not_taken && !pred_taken &&
                    pred_next_pc == l_pc + 32'd4)
            else begin
                $display("Mismatch at %0t: cold lookup of %h predicted %h", $time, l_pc,
                         pred_next_pc);
                errors++;
            end
        end
        report_test("cold lookup");

        // Train one branch taken until it predicts taken
        start_test();
        br_pc = 32'h0000_1040;
        tries = 0;
        lookup_only(br_pc);
        while (!(pred_taken && pred_counter >= weak_taken) && tries < 16) begin
            resolve_only(br_pc, pred_index, pred_counter, 1'b1, kind_branch, 32'h0000_1800);
            lookup_only(br_pc);
            tries++;
        end
        assert (pred_taken && pred_next_pc == 32'h0000_1800)
        else begin
            $display("Mismatch at %0t: branch at %h went to %h after %0d resolves", $time,
                     br_pc, pred_next_pc, tries);
            errors++;
        end
        report_test("branch training");

        start_test();
        jmp_pc = 32'h0000_2084;
        lookup_only(jmp_pc);
        resolve_only(jmp_pc, pred_index, pred_counter, 1'b1, kind_jump, 32'h0000_3000);
        lookup_only(jmp_pc);
        assert (pred_taken && pred_next_pc == 32'h0000_3000)
        else begin
            $display("Mismatch at %0t: jump at %h went to %h", $time, jmp_pc, pred_next_pc);
            errors++;
        end
        report_test("jump redirect");

        // Same slot as the trained branch but another tag
        start_test();
        l_pc = br_pc ^ 32'h0010_0000;
        lookup_only(l_pc);
        assert (!btb_hit && pred_next_pc == l_pc + 32'd4)
        else begin
            $display("Mismatch at %0t: aliased %h hit the buffer", $time, l_pc);
            errors++;
        end
        report_test("tag mismatch");

        start_test();
        r_pc = '0;
        r_idx = '0;
        r_cnt = weak_not_taken;
        r_kind = kind_branch;
        r_taken = 1'b0;
        for (int i = 0; i < 260; i++) begin
            rnd = next_random();
            do_resolve = (q_pc.size() > 0) && (rnd[21] || q_pc.size() > 3);
            if (do_resolve) begin
                r_pc = q_pc.pop_front();
                r_idx = q_idx.pop_front();
                r_cnt = q_cnt.pop_front();
                r_kind = r_pc[6] ? kind_jump : kind_branch;
                r_taken = (r_kind == kind_jump) || (rnd[23:22] != 2'b00);
            end
            l_valid = (rnd[19:16] != 4'd0);
            l_pc = 32'h0000_2000 + {rnd[28:24], 2'b00};
            if (rnd[30:29] == 2'b00) begin
                l_pc = l_pc ^ 32'h0004_0000;
            end
            drive_cycle(l_valid, l_pc, do_resolve, r_pc, r_idx, r_cnt, r_taken, r_kind,
                        r_pc + 32'h0000_0400);
            if (l_valid) begin
                q_pc.push_back(pred_pc);
                q_idx.push_back(pred_index);
                q_cnt.push_back(pred_counter);
            end
        end
        wait_pred_idle();
        drive_cycle(1'b0, '0, 1'b0, '0, '0, weak_not_taken, 1'b0, kind_branch, '0);
        assert (predictions_made == 16'(branch_resolves) &&
                correct_predictions == 16'(m_correct) && cycle_count == tally)
        else begin
            $display("Mismatch at %0t: final stats %0d %0d %0d", $time, cycle_count,
                     predictions_made, correct_predictions);
            errors++;
        end
        report_test("random stream");

        $display("tests %0d, lookups %0d, resolves %0d, errors %0d", tests_run, lookups,
                 resolves, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verification/tb_clock.sv
`timescale 1ns/1ns
`default_nettype none

// Free-running 8 ns clock
module tb_clock (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

endmodule

`default_nettype wire
